//--- vlog.f
logic/tiles_pkg.sv
logic/ps2_key_decoder.sv
logic/tile_fsm.sv
logic/step_timer.sv
logic/tile_mover.sv
logic/score_keeper.sv
logic/block_painter.sv
logic/seg7_digit.sv
logic/tiles_top.sv
tests/tiles_properties.sv
tests/tiles_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tiles_tb \
  -f vlog.f -o sim_tiles || exit 1
./obj_dir/sim_tiles +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && echo "Simulation reported a failure" && exit 1
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"

//--- tests/tiles_tb.sv
module tiles_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tiles_pkg::*;

  localparam int HIT = 0;
  localparam int WRONG = 1;
  localparam int NO_SPACE = 2;
  localparam logic [7:0] SPACE_KEY = 8'h29;
  localparam logic [7:0] BREAK_BYTE = 8'hf0;
  localparam logic [7:0] EXT_BYTE = 8'he0;
  // Nine landings of 113 steps each with every step at the slowest difficulty
  localparam int LANDINGS = 9;
  localparam int IDLE_CYCLES = 1000;
  localparam int LONGEST_STEP = 514 + 472;
  localparam int CYCLE_LIMIT = (LANDINGS * 113 + 4) * LONGEST_STEP + IDLE_CYCLES + 1000;

  logic       clk;
  logic       reset;
  logic       start;
  logic [1:0] difficulty;
  logic [7:0] ps2_byte;
  logic       ps2_valid;
  pixel_t     pixel;
  logic       plot;
  logic [6:0] hex0;
  logic [6:0] hex1;

  // Sweep tracking updated on the rising edge
  int          cycles = 0;
  int          sweeps = 0;
  int          draws = 0;
  int          run = 0;
  int          gap = 0;
  bit          in_sweep = 0;
  int          model_row = 0;
  int          cur_lane = 0;
  int          exp_score = 0;
  int          exp_bonus = 1;
  logic [31:0] rng = 32'ha447;
  string       test_name = "reset";

  tiles_top uut (
    .clk(clk), .reset(reset), .start(start), .difficulty(difficulty),
    .ps2_byte(ps2_byte), .ps2_valid(ps2_valid),
    .pixel(pixel), .plot(plot), .hex0(hex0), .hex1(hex1)
  );

  bind tiles_top tiles_properties props (
    .clk(clk), .reset(reset), .plot(plot), .step(step), .timer_run(timer_run),
    .pixel(pixel), .tile(tile), .ones(ones)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_eq(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("Error: %s, %s: expected %0d, actual %0d", test_name, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int lane_edge(input int lane);
    case (lane)
      0: return 4;
      1: return 44;
      2: return 84;
      3: return 124;
      default: return -1;
    endcase
  endfunction

  function automatic int lane_of(input int x);
    for (int i = 0; i < 4; i++) begin
      if (lane_edge(i) == x) return i;
    end
    return -1;
  endfunction

  function automatic int step_delay(input logic [1:0] d);
    case (d)
      2'd0: return 84;
      2'd1: return 42;
      2'd2: return 236;
      default: return 472;
    endcase
  endfunction

  function automatic logic [7:0] key_code(input int lane);
    case (lane)
      0: return 8'h1d;  // w
      1: return 8'h1c;  // a
      2: return 8'h1b;  // s
      default: return 8'h23;  // d
    endcase
  endfunction

  // Active low, bit 0 top, bit 6 middle
  function automatic int seg_value(input logic [6:0] seg);
    case (seg)
      7'b1000000: return 0;
      7'b1111001: return 1;
      7'b0100100: return 2;
      7'b0110000: return 3;
      7'b0011001: return 4;
      7'b0010010: return 5;
      7'b0000010: return 6;
      7'b1111000: return 7;
      7'b0000000: return 8;
      7'b0010000: return 9;
      default: return 99;  // Not a decimal digit
    endcase
  endfunction

  function automatic int read_score();
    return seg_value(hex1) * 10 + seg_value(hex0);
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "Timeout");
    end
    if (uut.props.failures != 0) begin
      $display("A concurrent assertion on the DUT failed");
      $display("TEST FAILED");
      $fatal(1, "Assertion failure");
    end
    if (plot) begin
      if (!in_sweep) begin
        in_sweep = 1;
        run = 0;
        sweeps++;
        if (sweeps > 1) begin
          // One LOAD cycle before DRAW and the hold before ERASE
          check_eq("gap before sweep", (sweeps % 2 == 1) ? 1 : step_delay(difficulty) + 1, gap);
        end
        if (sweeps % 2 == 1) begin
          model_row = (model_row == 112) ? 0 : model_row + 1;
          if (model_row != 0) begin
            check_eq("lane kept while falling", cur_lane, lane_of(pixel.x));
          end
          cur_lane = lane_of(pixel.x);
          check_eq("lane edge of first pixel", 1, (cur_lane >= 0) ? 1 : 0);
          draws++;
        end
      end
      check_eq("pixel x", lane_edge(cur_lane) + run / 8, pixel.x);
      check_eq("pixel y", model_row + run % 8, pixel.y);
      check_eq("pixel colour", (sweeps % 2 == 1) ? 7 : 0, pixel.colour);
      run++;
    end else begin
      if (in_sweep) begin
        check_eq("sweep length", 256, run);
        in_sweep = 0;
        gap = 0;
      end
      gap++;
    end
  end

  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    ps2_byte = b;
    ps2_valid = 1'b1;
    @(negedge clk);
    ps2_valid = 1'b0;
  endtask

  task automatic press_key(input logic [7:0] code);
    send_byte(code);
  endtask

  task automatic release_key(input logic [7:0] code);
    send_byte(BREAK_BYTE);
    send_byte(code);
  endtask

  task automatic pick_difficulty();
    rng = next_random(rng);
    difficulty = rng[17:16];
  endtask

  // Returns on the falling edge after a DRAW of the given row has begun
  task automatic wait_row(input int row);
    int seen;
    bit found;
    seen = draws;
    found = 0;
    while (!found) begin
      @(negedge clk);
      if (draws != seen) begin
        seen = draws;
        found = (model_row == row);
      end
    end
  endtask

  task automatic land(input int mode);
    int key;
    bit space;
    wait_row(112);
    pick_difficulty();
    space = (mode != NO_SPACE);
    key = cur_lane;
    if (mode == WRONG) begin
      rng = next_random(rng);
      key = (cur_lane + 1 + int'(rng[23:16]) % 3) % 4;
    end
    if (space) press_key(SPACE_KEY);
    press_key(key_code(key));
    if (space && key == cur_lane) begin
      exp_score = (exp_score + exp_bonus) % 100;
      if (exp_bonus < 8) exp_bonus = exp_bonus * 2;
    end else if (space) begin
      exp_bonus = 1;  // Other lane key held
    end
    wait_row(0);
    check_eq("score after landing", exp_score, read_score());
    if (space) release_key(SPACE_KEY);
    release_key(key_code(key));
  endtask

  task automatic idle_test();
    test_name = "idle";
    repeat (IDLE_CYCLES) @(negedge clk);
    check_eq("sweeps before start", 0, sweeps);
    check_eq("score", 0, read_score());
  endtask

  task automatic sweep_test();
    test_name = "sweeps";
    pick_difficulty();
    start = 1'b1;
    wait_row(1);
    check_eq("lane after reset", 0, cur_lane);
    wait_row(2);  // First DRAW, its ERASE and both gaps are checked by now
  endtask

  task automatic streak_test();
    test_name = "bonus streak";
    land(HIT);
    land(HIT);
    land(HIT);
    check_eq("three hits", 7, read_score());
    land(HIT);
    check_eq("decimal carry", 15, read_score());
  endtask

  task automatic wrong_key_test();
    test_name = "wrong key";
    land(WRONG);
    check_eq("miss", 15, read_score());
    land(HIT);
    check_eq("hit after bonus reset", 16, read_score());
  endtask

  task automatic no_space_test();
    test_name = "no space";
    land(NO_SPACE);
    check_eq("lane key alone", 16, read_score());
  endtask

  task automatic key_release_test();
    int key;
    test_name = "key release";
    wait_row(111);
    key = cur_lane;
    press_key(SPACE_KEY);
    press_key(key_code(key));
    wait_row(112);
    release_key(key_code(key));
    wait_row(0);
    check_eq("released lane key", 16, read_score());
    release_key(SPACE_KEY);
  endtask

  task automatic extended_code_test();
    test_name = "extended code";
    wait_row(112);
    press_key(SPACE_KEY);
    send_byte(EXT_BYTE);
    send_byte(key_code(cur_lane));  // Ignored after E0
    wait_row(0);
    check_eq("extended lane code", 16, read_score());
    release_key(SPACE_KEY);
  endtask

  initial begin
    reset = 1'b0;
    start = 1'b0;
    difficulty = 2'd0;
    ps2_byte = 8'h00;
    ps2_valid = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b1;
    idle_test();
    sweep_test();
    streak_test();
    wrong_key_test();
    no_space_test();
    key_release_test();
    extended_code_test();
    if (uut.props.failures == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "Assertion failures in the property checker");
    end
  end

endmodule

//--- tests/tiles_properties.sv
module tiles_properties (
  input logic              clk,
  input logic              reset,
  input logic              plot,
  input logic              step,
  input logic              timer_run,
  input tiles_pkg::pixel_t pixel,
  input tiles_pkg::tile_t  tile,
  input tiles_pkg::digit_t ones
);
  timeunit 1ns;
  timeprecision 1ps;
  import tiles_pkg::*;

  int           failures = 0;  // Read by the testbench
  logic         started;
  logic [X_W:0] left_edge;
  logic [X_W:0] x_wide;

  // Set by the first LOAD, so low only while the FSM is in IDLE
  always_ff @(posedge clk) begin
    if (!reset) begin
      started <= 1'b0;
    end else if (step) begin
      started <= 1'b1;
    end
  end

  assign left_edge = {1'b0, LANE_X[tile.lane]};
  assign x_wide    = {1'b0, pixel.x};

  plot_quiet: assert property (@(posedge clk) disable iff (!reset)
    (!started || timer_run) |-> !plot)
    else begin
      $error("plot high while the FSM is idle or holding");
      failures++;
    end

  x_in_lane: assert property (@(posedge clk) disable iff (!reset)
    plot |-> (x_wide >= left_edge) && (x_wide < left_edge + 9'(BLOCK_W)))
    else begin
      $error("pixel x outside the block of lane %0d", tile.lane);
      failures++;
    end

  ones_decimal: assert property (@(posedge clk) disable iff (!reset) ones < 4'd10)
    else begin
      $error("ones digit is not decimal");
      failures++;
    end

  step_pulse: assert property (@(posedge clk) disable iff (!reset) step |=> !step)
    else begin
      $error("step held for more than one cycle");
      failures++;
    end

endmodule

//--- logic/tiles_top.sv
module tiles_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [1:0]       difficulty,
  input  logic [7:0]       ps2_byte,
  input  logic             ps2_valid,
  output tiles_pkg::pixel_t pixel,
  output logic             plot,
  output logic [6:0]       hex0,
  output logic [6:0]       hex1
);
  import tiles_pkg::*;

  keys_t      keys;
  tile_t      tile;
  digit_t     ones;
  digit_t     tens;
  logic       step;
  logic       paint;
  logic [2:0] paint_colour;
  logic       paint_done;
  logic       timer_run;
  logic       expired;
  logic       landing;

  ps2_key_decoder u_decoder (
    .clk(clk), .reset(reset),
    .ps2_byte(ps2_byte), .ps2_valid(ps2_valid),
    .keys(keys)
  );

  tile_fsm u_fsm (
    .clk(clk), .reset(reset),
    .start(start), .expired(expired), .paint_done(paint_done),
    .step(step), .paint(paint), .paint_colour(paint_colour),
    .timer_run(timer_run)
  );

  step_timer u_timer (
    .clk(clk), .reset(reset),
    .difficulty(difficulty), .timer_run(timer_run),
    .expired(expired)
  );

  tile_mover u_mover (
    .clk(clk), .reset(reset),
    .step(step), .tile(tile), .landing(landing)
  );

  score_keeper u_score (
    .clk(clk), .reset(reset),
    .step(step), .landing(landing), .tile_lane(tile.lane), .keys(keys),
    .ones(ones), .tens(tens)
  );

  block_painter u_painter (
    .clk(clk), .reset(reset),
    .paint(paint), .paint_colour(paint_colour), .tile(tile),
    .pixel(pixel), .plot(plot), .paint_done(paint_done)
  );

  seg7_digit u_hex0 (.digit(ones), .seg(hex0));  // Ones on the right display
  seg7_digit u_hex1 (.digit(tens), .seg(hex1));

endmodule

//--- logic/seg7_digit.sv
module seg7_digit (
  input  tiles_pkg::digit_t digit,
  output logic [6:0]        seg
);

  // Active low, bit 0 top, clockwise round the edge, bit 6 middle
  always_comb begin
    case (digit)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'ha:    seg = 7'b0001000;
      4'hb:    seg = 7'b0000011;  // Lower case b
      4'hc:    seg = 7'b1000110;
      4'hd:    seg = 7'b0100001;  // Lower case d
      4'he:    seg = 7'b0000110;
      default: seg = 7'b0001110;  // F
    endcase
  end

endmodule

//--- logic/block_painter.sv
module block_painter (
  input  logic             clk,
  input  logic             reset,
  input  logic             paint,
  input  logic [2:0]       paint_colour,
  input  tiles_pkg::tile_t tile,
  output tiles_pkg::pixel_t pixel,
  output logic             plot,
  output logic             paint_done
);
  import tiles_pkg::*;

  logic [PAINT_W-1:0]       count;
  logic [PAINT_W-OFF_W-1:0] column;
  logic [OFF_W-1:0]         offset;

  always_ff @(posedge clk) begin
    if (!reset) begin
      count <= '0;
    end else if (paint) begin
      count <= count + 1'b1;  // Wraps to 0 after the last pixel
    end else begin
      count <= '0;
    end
  end

  // Row offset is the low part so a column is painted top to bottom
  assign column = count[PAINT_W-1:OFF_W];
  assign offset = count[OFF_W-1:0];

  assign pixel.x      = LANE_X[tile.lane] + {{(X_W-PAINT_W+OFF_W){1'b0}}, column};
  assign pixel.y      = tile.row + {{(Y_W-OFF_W){1'b0}}, offset};
  assign pixel.colour = paint_colour;

  assign plot       = paint;
  assign paint_done = paint && (count == PAINT_W'(PAINT_COUNT - 1));

endmodule

//--- logic/score_keeper.sv
module score_keeper (
  input  logic              clk,
  input  logic              reset,
  input  logic              step,
  input  logic              landing,
  input  tiles_pkg::lane_t  tile_lane,
  input  tiles_pkg::keys_t  keys,
  output tiles_pkg::digit_t ones,
  output tiles_pkg::digit_t tens
);
  import tiles_pkg::*;

  logic [3:0] lane_keys;
  logic [3:0] lane_mask;
  logic       hit;
  logic       wrong;
  logic       judge;
  logic [3:0] bonus;
  logic [4:0] sum;
  logic [4:0] wrapped;

  // Lane order matches lane_t
  assign lane_keys = {keys.d, keys.s, keys.a, keys.w};
  assign lane_mask = 4'b0001 << tile_lane;
  assign hit       = |(lane_keys & lane_mask);
  assign wrong     = |(lane_keys & ~lane_mask);

  assign judge   = step && landing && keys.space;  // Space must be held
  assign sum     = {1'b0, ones} + {1'b0, bonus};
  assign wrapped = sum - 5'd10;

  always_ff @(posedge clk) begin
    if (!reset) begin
      ones  <= '0;
      tens  <= '0;
      bonus <= 4'd1;
    end else if (judge) begin
      if (hit) begin
        if (sum >= 5'd10) begin
          // Decimal carry into tens
          ones <= wrapped[3:0];
          tens <= (tens == 4'd9) ? 4'd0 : tens + 1'b1;
        end else begin
          ones <= sum[3:0];
        end
        if (bonus < BONUS_MAX) begin
          bonus <= {bonus[2:0], 1'b0};  // Double the streak bonus
        end
      end else if (wrong) begin
        bonus <= 4'd1;  // Streak broken
      end
    end
  end

endmodule

//--- logic/tile_mover.sv
module tile_mover (
  input  logic            clk,
  input  logic            reset,
  input  logic            step,
  output tiles_pkg::tile_t tile,
  output logic            landing
);
  import tiles_pkg::*;

  logic [3:0] lfsr;
  logic       feedback;
  lane_t      next_lane;

  // XNOR taps on bits 3 and 2, so all zeros is a legal state
  assign feedback = ~(lfsr[3] ^ lfsr[2]);

  always_ff @(posedge clk) begin
    if (!reset) begin
      lfsr <= '0;
    end else begin
      lfsr <= {lfsr[2:0], feedback};  // Free running
    end
  end

  always_comb begin
    case (lfsr[1:0])
      2'b11:   next_lane = 2'd0;
      2'b01:   next_lane = 2'd1;
      2'b10:   next_lane = 2'd2;
      default: next_lane = 2'd3;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      tile.lane <= 2'd0;
      tile.row  <= '0;
    end else if (step) begin
      if (tile.row == BOTTOM_ROW) begin
        // New tile at the top of a random lane
        tile.row  <= '0;
        tile.lane <= next_lane;
      end else begin
        tile.row <= tile.row + 1'b1;
      end
    end
  end

  assign landing = (tile.row == BOTTOM_ROW);

endmodule

//--- logic/step_timer.sv
module step_timer (
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] difficulty,
  input  logic       timer_run,
  output logic       expired
);
  import tiles_pkg::*;

  logic [TIMER_W-1:0] count;

  // Reload while idle so a new difficulty applies at the next hold
  always_ff @(posedge clk) begin
    if (!reset) begin
      count <= '0;
    end else if (!timer_run) begin
      count <= STEP_DELAY[difficulty];
    end else if (count != '0) begin
      count <= count - 1'b1;  // Stops at zero
    end
  end

  assign expired = (count == '0);

endmodule

//--- logic/tile_fsm.sv
module tile_fsm (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       expired,
  input  logic       paint_done,
  output logic       step,
  output logic       paint,
  output logic [2:0] paint_colour,
  output logic       timer_run
);
  import tiles_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    DRAW,
    HOLD,
    ERASE
  } state_t;

  state_t state;
  state_t next_state;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start) begin
          next_state = LOAD;
        end
      end
      LOAD: next_state = DRAW;  // Single cycle, tile moves here
      DRAW: begin
        if (paint_done) begin
          next_state = HOLD;
        end
      end
      HOLD: begin
        if (expired) begin
          next_state = ERASE;
        end
      end
      ERASE: begin
        if (paint_done) begin
          next_state = LOAD;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Moore outputs
  assign step         = (state == LOAD);
  assign paint        = (state == DRAW) || (state == ERASE);
  assign paint_colour = (state == DRAW) ? COLOUR_BLOCK : COLOUR_BACK;
  assign timer_run    = (state == HOLD);

endmodule

//--- logic/ps2_key_decoder.sv
module ps2_key_decoder (
  input  logic            clk,
  input  logic            reset,
  input  logic [7:0]      ps2_byte,
  input  logic            ps2_valid,
  output tiles_pkg::keys_t keys
);
  import tiles_pkg::*;

  // What the next byte means
  typedef enum logic [1:0] {
    MAKE,
    BREAK,
    EXT
  } track_t;

  track_t state;
  logic   pressed;

  assign pressed = (state == MAKE);  // Code sets the flag in MAKE, clears it in BREAK

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= MAKE;
      keys  <= '0;
    end else if (ps2_valid) begin
      if (ps2_byte == EXT_PREFIX) begin
        state <= EXT;
      end else if (ps2_byte == BREAK_PREFIX) begin
        // Extended break is E0 F0 xx, keep ignoring it
        if (state != EXT) begin
          state <= BREAK;
        end
      end else begin
        state <= MAKE;  // Any code byte ends the sequence
        if (state != EXT) begin
          case (ps2_byte)
            W_CODE:     keys.w     <= pressed;
            A_CODE:     keys.a     <= pressed;
            S_CODE:     keys.s     <= pressed;
            D_CODE:     keys.d     <= pressed;
            SPACE_CODE: keys.space <= pressed;
            default: ;  // Keys the game does not use
          endcase
        end
      end
    end
  end

endmodule

//--- logic/tiles_pkg.sv
package tiles_pkg;

  // Display coordinate widths for the 160x120 screen
  localparam int X_W = 8;
  localparam int Y_W = 7;

  // Block geometry
  localparam int BLOCK_W = 32;
  localparam int BLOCK_H = 8;
  localparam int PAINT_COUNT = BLOCK_W * BLOCK_H;  // Pixels per sweep
  localparam int PAINT_W = $clog2(PAINT_COUNT);
  localparam int OFF_W = $clog2(BLOCK_H);          // Row offset bits, fastest

  localparam logic [Y_W-1:0] BOTTOM_ROW = 7'd112;

  // Left edge of each lane, indexed by lane number
  localparam logic [X_W-1:0] LANE_X [4] = '{8'd4, 8'd44, 8'd84, 8'd124};

  // Hold time per difficulty, board ratios at simulation scale
  localparam int TIMER_W = 9;
  localparam logic [TIMER_W-1:0] STEP_DELAY [4] = '{9'd84, 9'd42, 9'd236, 9'd472};

  localparam logic [3:0] BONUS_MAX = 4'd8;

  // PS/2 set 2 scan codes
  localparam logic [7:0] W_CODE       = 8'h1d;
  localparam logic [7:0] A_CODE       = 8'h1c;
  localparam logic [7:0] S_CODE       = 8'h1b;
  localparam logic [7:0] D_CODE       = 8'h23;
  localparam logic [7:0] SPACE_CODE   = 8'h29;
  localparam logic [7:0] BREAK_PREFIX = 8'hf0;
  localparam logic [7:0] EXT_PREFIX   = 8'he0;

  localparam logic [2:0] COLOUR_BLOCK = 3'd7;  // White
  localparam logic [2:0] COLOUR_BACK  = 3'd0;  // Black

  typedef logic [1:0] lane_t;  // 0 w, 1 a, 2 s, 3 d

  typedef struct packed {
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    logic [2:0]     colour;
  } pixel_t;

  // Held-key flags
  typedef struct packed {
    logic w;
    logic a;
    logic s;
    logic d;
    logic space;
  } keys_t;

  typedef struct packed {
    lane_t          lane;
    logic [Y_W-1:0] row;
  } tile_t;

  typedef logic [3:0] digit_t;

endpackage
